// ==== hdl/battle_pkg.sv ====
// battle scene shared definitions
package battle_pkg;

   // screen and sprite types
   typedef logic [9:0] coord_t;
   // eight creatures on the sheet
   typedef logic [2:0] poke_id_t;
   typedef logic [6:0] hp_t;
   typedef logic [18:0] sprite_addr_t;
   // one colour channel
   typedef logic [7:0] color_t;

   // register word offsets
   typedef enum logic [3:0] {
      REG_MY_ID    = 4'h0,
      REG_ENEMY_ID = 4'h4,
      REG_MAX_HP   = 4'h8,
      REG_CUR_HP   = 4'hC
   } reg_addr_e;

   // sprite tile size, square
   localparam int SPRITE_W = 56;
   localparam int SPRITE_H = 56;
   // sheet is four tiles wide
   localparam int SHEET_W = 224;

   // team slot origins
   localparam coord_t MY_X = 10'd250;
   localparam coord_t MY_Y = 10'd290;
   localparam coord_t ENEMY_X = 10'd410;
   localparam coord_t ENEMY_Y = 10'd160;

   // health bar interior, border sits one pixel outside
   localparam coord_t HP_X = 10'd280;
   localparam coord_t HP_Y = 10'd270;
   localparam int HP_W = 50;
   localparam int HP_H = 5;

   // bar colours as {r, g, b}
   localparam logic [23:0] HP_GREEN  = 24'h41_ff_74;
   localparam logic [23:0] HP_YELLOW = 24'h41_cc_00;
   localparam logic [23:0] HP_RED    = 24'hff_33_00;
   localparam logic [23:0] HP_WHITE  = 24'hff_ff_ff;
   localparam logic [23:0] HP_BLACK  = 24'h00_00_00;

   // health after reset
   localparam hp_t RESET_MAX_HP = 7'd100;
   localparam hp_t RESET_CUR_HP = 7'd100;

   // axi4-lite bus widths
   localparam int AXI_ADDR_W = 4;
   localparam int AXI_DATA_W = 32;

endpackage

// ==== hdl/battle_regs.sv ====
// battle configuration registers
`timescale 1ns/1ns
module battle_regs (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // write address and data
   input  logic [battle_pkg::AXI_ADDR_W-1:0]    awaddr,
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [battle_pkg::AXI_DATA_W-1:0]    wdata,
   input  logic [3:0]                           wstrb,
   input  logic                                 wvalid,
   output logic                                 wready,
   // write response
   output logic [1:0]                           bresp,
   output logic                                 bvalid,
   input  logic                                 bready,
   // read address and data
   input  logic [battle_pkg::AXI_ADDR_W-1:0]    araddr,
   input  logic                                 arvalid,
   output logic                                 arready,
   output logic [battle_pkg::AXI_DATA_W-1:0]    rdata,
   output logic [1:0]                           rresp,
   output logic                                 rvalid,
   input  logic                                 rready,
   // configuration to the pixel path
   output battle_pkg::poke_id_t                 my_id,
   output battle_pkg::poke_id_t                 enemy_id,
   output battle_pkg::hp_t                      max_hp,
   output battle_pkg::hp_t                      cur_hp
);

   logic                              wr_ready_q;
   logic                              wr_fire;
   logic [battle_pkg::AXI_DATA_W-1:0] rd_word;

   // address and data are taken together
   assign awready = wr_ready_q;
   assign wready  = wr_ready_q;
   assign wr_fire = wr_ready_q & awvalid & wvalid;

   // always OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   // one-cycle ready pulse, none while a response waits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ready_q <= 1'b0;
         bvalid     <= 1'b0;
      end else begin
         wr_ready_q <= awvalid & wvalid & ~bvalid & ~wr_ready_q;
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // register file, low byte lane only
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         my_id    <= '0;
         enemy_id <= '0;
         max_hp   <= battle_pkg::RESET_MAX_HP;
         cur_hp   <= battle_pkg::RESET_CUR_HP;
      end else if (wr_fire && wstrb[0]) begin
         case (battle_pkg::reg_addr_e'(awaddr))
            battle_pkg::REG_MY_ID:    my_id    <= battle_pkg::poke_id_t'(wdata);
            battle_pkg::REG_ENEMY_ID: enemy_id <= battle_pkg::poke_id_t'(wdata);
            battle_pkg::REG_MAX_HP:   max_hp   <= battle_pkg::hp_t'(wdata);
            battle_pkg::REG_CUR_HP:   cur_hp   <= battle_pkg::hp_t'(wdata);
            // unmapped offset, write dropped
            default: ;
         endcase
      end
   end

   // read mux, zero-extended
   always_comb begin
      rd_word = '0;
      case (battle_pkg::reg_addr_e'(araddr))
         battle_pkg::REG_MY_ID:    rd_word[$bits(my_id)-1:0]    = my_id;
         battle_pkg::REG_ENEMY_ID: rd_word[$bits(enemy_id)-1:0] = enemy_id;
         battle_pkg::REG_MAX_HP:   rd_word[$bits(max_hp)-1:0]   = max_hp;
         battle_pkg::REG_CUR_HP:   rd_word[$bits(cur_hp)-1:0]   = cur_hp;
         default: ;
      endcase
   end

   // read channel
   // arready drops while data waits for rready
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= '0;
      end else if (arready && arvalid) begin
         arready <= 1'b0;
         rvalid  <= 1'b1;
         rdata   <= rd_word;
      end else if (rvalid) begin
         if (rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
         end
      end else begin
         arready <= 1'b1;
      end
   end

endmodule

// ==== hdl/sprite_window.sv ====
// creature sprite window
`timescale 1ns/1ns
module sprite_window #(
   parameter battle_pkg::coord_t ORIGIN_X = 10'd0,
   parameter battle_pkg::coord_t ORIGIN_Y = 10'd0,
   // 0 back-facing column group, 1 front-facing
   parameter int COL_BASE = 0
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  battle_pkg::coord_t       draw_x,
   input  battle_pkg::coord_t       draw_y,
   input  battle_pkg::poke_id_t     poke_id,
   output battle_pkg::sprite_addr_t sprite_addr,
   output logic                     hit
);

   battle_pkg::coord_t       dx;
   battle_pkg::coord_t       dy;
   logic                     in_win;
   logic [1:0]               tile_row;
   logic [1:0]               tile_col;
   battle_pkg::sprite_addr_t addr_next;

   // offsets wrap below the origin, so the lower bound is checked on its own
   assign dx = draw_x - ORIGIN_X;
   assign dy = draw_y - ORIGIN_Y;
   assign in_win = (draw_x >= ORIGIN_X) && (dx < battle_pkg::SPRITE_W) &&
                   (draw_y >= ORIGIN_Y) && (dy < battle_pkg::SPRITE_H);

   // two creatures per tile row
   assign tile_row = poke_id[2:1];
   // odd ids skip two columns
   assign tile_col = 2'(COL_BASE) + {poke_id[0], 1'b0};

   // column offset plus full sheet rows
   assign addr_next = battle_pkg::sprite_addr_t'(
      tile_col * battle_pkg::SPRITE_W + dx +
      battle_pkg::SHEET_W * (tile_row * battle_pkg::SPRITE_H + dy));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sprite_addr <= '0;
         hit         <= 1'b0;
      end else begin
         sprite_addr <= in_win ? addr_next : '0;
         hit         <= in_win;
      end
   end

endmodule

// ==== hdl/hp_bar.sv ====
// player health bar
`timescale 1ns/1ns
module hp_bar (
   input  logic                 clk,
   input  logic                 arst_n,
   input  battle_pkg::coord_t   draw_x,
   input  battle_pkg::coord_t   draw_y,
   input  battle_pkg::hp_t      max_hp,
   input  battle_pkg::hp_t      cur_hp,
   output battle_pkg::color_t   hp_r,
   output battle_pkg::color_t   hp_g,
   output battle_pkg::color_t   hp_b,
   output logic                 is_hpbar
);

   logic [12:0] fill_prod;
   logic [12:0] fill_quot;
   logic [5:0]  fill_w;
   logic        in_outer;
   logic        in_inner;
   logic        in_fill;
   logic [23:0] fill_rgb;
   logic [23:0] pix_rgb;

   // HP_W * cur / max, 127 * 50 fits 13 bits
   assign fill_prod = 13'(cur_hp) * 13'(battle_pkg::HP_W);
   // zero max gives an empty bar
   assign fill_quot = (max_hp == '0) ? '0 : fill_prod / 13'(max_hp);
   // cur above max would overrun the interior
   assign fill_w = (fill_quot > battle_pkg::HP_W) ? 6'(battle_pkg::HP_W) : fill_quot[5:0];

   // interior box
   assign in_inner = (draw_x >= battle_pkg::HP_X) &&
                     (draw_x < battle_pkg::HP_X + battle_pkg::HP_W) &&
                     (draw_y >= battle_pkg::HP_Y) &&
                     (draw_y < battle_pkg::HP_Y + battle_pkg::HP_H);
   // interior plus the one-pixel ring
   assign in_outer = (draw_x >= battle_pkg::HP_X - 1) &&
                     (draw_x <= battle_pkg::HP_X + battle_pkg::HP_W) &&
                     (draw_y >= battle_pkg::HP_Y - 1) &&
                     (draw_y <= battle_pkg::HP_Y + battle_pkg::HP_H);

   // filled columns start at the left edge
   assign in_fill = in_inner && (draw_x < battle_pkg::HP_X + fill_w);

   // above one half green, above one fifth yellow
   always_comb begin
      if ((fill_w * 2) > battle_pkg::HP_W) begin
         fill_rgb = battle_pkg::HP_GREEN;
      end else if ((fill_w * 5) > battle_pkg::HP_W) begin
         fill_rgb = battle_pkg::HP_YELLOW;
      end else begin
         fill_rgb = battle_pkg::HP_RED;
      end
   end

   // ring black, fill coloured, rest white
   always_comb begin
      if (in_outer && !in_inner) begin
         pix_rgb = battle_pkg::HP_BLACK;
      end else if (in_fill) begin
         pix_rgb = fill_rgb;
      end else begin
         pix_rgb = battle_pkg::HP_WHITE;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         {hp_r, hp_g, hp_b} <= battle_pkg::HP_WHITE;
         is_hpbar           <= 1'b0;
      end else begin
         {hp_r, hp_g, hp_b} <= pix_rgb;
         is_hpbar           <= in_outer;
      end
   end

endmodule

// ==== hdl/battle_scene.sv ====
// battle scene pixel top
`timescale 1ns/1ns
module battle_scene (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // scan position
   input  battle_pkg::coord_t                   draw_x,
   input  battle_pkg::coord_t                   draw_y,
   // axi4-lite slave
   input  logic [battle_pkg::AXI_ADDR_W-1:0]    awaddr,
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [battle_pkg::AXI_DATA_W-1:0]    wdata,
   input  logic [3:0]                           wstrb,
   input  logic                                 wvalid,
   output logic                                 wready,
   output logic [1:0]                           bresp,
   output logic                                 bvalid,
   input  logic                                 bready,
   input  logic [battle_pkg::AXI_ADDR_W-1:0]    araddr,
   input  logic                                 arvalid,
   output logic                                 arready,
   output logic [battle_pkg::AXI_DATA_W-1:0]    rdata,
   output logic [1:0]                           rresp,
   output logic                                 rvalid,
   input  logic                                 rready,
   // pixel outputs, one cycle after draw_x and draw_y
   output battle_pkg::sprite_addr_t             my_sprite_addr,
   output logic                                 is_myteam,
   output battle_pkg::sprite_addr_t             enemy_sprite_addr,
   output logic                                 is_enemyteam,
   output battle_pkg::color_t                   hp_r,
   output battle_pkg::color_t                   hp_g,
   output battle_pkg::color_t                   hp_b,
   output logic                                 is_hpbar
);

   battle_pkg::poke_id_t my_id;
   battle_pkg::poke_id_t enemy_id;
   battle_pkg::hp_t      max_hp;
   battle_pkg::hp_t      cur_hp;

   battle_regs u_battle_regs (
      .clk      (clk),      .arst_n   (arst_n),
      .awaddr   (awaddr),   .awvalid  (awvalid),  .awready  (awready),
      .wdata    (wdata),    .wstrb    (wstrb),    .wvalid   (wvalid),
      .wready   (wready),   .bresp    (bresp),    .bvalid   (bvalid),
      .bready   (bready),   .araddr   (araddr),   .arvalid  (arvalid),
      .arready  (arready),  .rdata    (rdata),    .rresp    (rresp),
      .rvalid   (rvalid),   .rready   (rready),
      .my_id    (my_id),    .enemy_id (enemy_id),
      .max_hp   (max_hp),   .cur_hp   (cur_hp)
   );

   // back-facing sprites in the even columns
   sprite_window #(
      .ORIGIN_X (battle_pkg::MY_X),
      .ORIGIN_Y (battle_pkg::MY_Y),
      .COL_BASE (0)
   ) u_my_window (
      .clk         (clk),
      .arst_n      (arst_n),
      .draw_x      (draw_x),
      .draw_y      (draw_y),
      .poke_id     (my_id),
      .sprite_addr (my_sprite_addr),
      .hit         (is_myteam)
   );

   // front-facing sprites one column to the right
   sprite_window #(
      .ORIGIN_X (battle_pkg::ENEMY_X),
      .ORIGIN_Y (battle_pkg::ENEMY_Y),
      .COL_BASE (1)
   ) u_enemy_window (
      .clk         (clk),
      .arst_n      (arst_n),
      .draw_x      (draw_x),
      .draw_y      (draw_y),
      .poke_id     (enemy_id),
      .sprite_addr (enemy_sprite_addr),
      .hit         (is_enemyteam)
   );

   hp_bar u_hp_bar (
      .clk      (clk),
      .arst_n   (arst_n),
      .draw_x   (draw_x),
      .draw_y   (draw_y),
      .max_hp   (max_hp),
      .cur_hp   (cur_hp),
      .hp_r     (hp_r),
      .hp_g     (hp_g),
      .hp_b     (hp_b),
      .is_hpbar (is_hpbar)
   );

endmodule

// ==== test/tb_battle_scene.sv ====
// battle scene testbench
`timescale 1ns/1ns
module tb_battle_scene;

   localparam int MAX_ROWS = 192;

   logic clk = 1'b0;
   logic arst_n;
   battle_pkg::coord_t draw_x, draw_y;
   logic [battle_pkg::AXI_ADDR_W-1:0] awaddr, araddr;
   logic [battle_pkg::AXI_DATA_W-1:0] wdata, rdata;
   logic [3:0] wstrb;
   logic [1:0] bresp, rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   battle_pkg::sprite_addr_t my_sprite_addr, enemy_sprite_addr;
   logic is_myteam, is_enemyteam, is_hpbar;
   battle_pkg::color_t hp_r, hp_g, hp_b;

   // stimulus table and expected outputs
   string t_name [MAX_ROWS];
   battle_pkg::poke_id_t t_my [MAX_ROWS], t_en [MAX_ROWS];
   battle_pkg::hp_t t_max [MAX_ROWS], t_cur [MAX_ROWS];
   battle_pkg::coord_t t_x [MAX_ROWS], t_y [MAX_ROWS];
   battle_pkg::sprite_addr_t x_my [MAX_ROWS], x_en [MAX_ROWS];
   logic x_myhit [MAX_ROWS], x_enhit [MAX_ROWS], x_bar [MAX_ROWS];
   logic [23:0] x_rgb [MAX_ROWS];
   int n_rows = 0;
   int cycles = 0;
   logic [31:0] lcg_state = 32'h84e0_ea1e;

   always #5 clk = ~clk;

   battle_scene u_battle_scene (.*);

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "run stopped");
   endtask

   // limit scales with the table length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= (n_rows * 40) + 200) begin
         $display("timeout: DUT did not respond within %0d cycles", cycles);
         abort_run();
      end
   end

   task automatic check_addr(input string name, input battle_pkg::sprite_addr_t exp, act);
      if (act !== exp) begin
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, act);
      if (act !== exp) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_color(input string name, input battle_pkg::color_t exp, act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_hp(input string name, input battle_pkg::hp_t exp, act);
      if (act !== exp) begin
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] exp, act);
      if (act !== exp) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic in_window(input int ox, input int oy, input int x, input int y);
      return x >= ox && x < ox + battle_pkg::SPRITE_W && y >= oy && y < oy + battle_pkg::SPRITE_H;
   endfunction

   // tile row id/2 and tile column col_base plus twice the low id bit
   function automatic battle_pkg::sprite_addr_t ref_addr(input int id, input int col_base,
         input int ox, input int oy, input int x, input int y);
      int col;
      int row;
      col = col_base + 2 * (id % 2);
      row = id / 2;
      if (!in_window(ox, oy, x, y))
         return '0;
      return battle_pkg::sprite_addr_t'(col * battle_pkg::SPRITE_W + (x - ox) +
         battle_pkg::SHEET_W * (row * battle_pkg::SPRITE_H + (y - oy)));
   endfunction

   // interior plus one-pixel ring
   function automatic logic on_bar(input int x, input int y);
      int hx = battle_pkg::HP_X;
      int hy = battle_pkg::HP_Y;
      return x >= hx - 1 && x <= hx + battle_pkg::HP_W && y >= hy - 1 &&
             y <= hy + battle_pkg::HP_H;
   endfunction

   function automatic logic [23:0] ref_rgb(input int x, input int y, input int mx, input int cur);
      int hx = battle_pkg::HP_X;
      int hy = battle_pkg::HP_Y;
      int fill;
      logic inner;
      fill = (mx == 0) ? 0 : (battle_pkg::HP_W * cur) / mx;
      if (fill > battle_pkg::HP_W)
         fill = battle_pkg::HP_W;
      inner = x >= hx && x < hx + battle_pkg::HP_W && y >= hy && y < hy + battle_pkg::HP_H;
      if (on_bar(x, y) && !inner)
         return battle_pkg::HP_BLACK;
      if (inner && x < hx + fill) begin
         if (2 * fill > battle_pkg::HP_W)
            return battle_pkg::HP_GREEN;
         if (5 * fill > battle_pkg::HP_W)
            return battle_pkg::HP_YELLOW;
         return battle_pkg::HP_RED;
      end
      return battle_pkg::HP_WHITE;
   endfunction

   task automatic add_row(input string name, input int my, input int en, input int mx,
         input int cur, input int x, input int y);
      t_name[n_rows] = name;
      t_my[n_rows] = my;
      t_en[n_rows] = en;
      t_max[n_rows] = mx;
      t_cur[n_rows] = cur;
      t_x[n_rows] = x;
      t_y[n_rows] = y;
      x_my[n_rows] = ref_addr(my, 0, battle_pkg::MY_X, battle_pkg::MY_Y, x, y);
      x_myhit[n_rows] = in_window(battle_pkg::MY_X, battle_pkg::MY_Y, x, y);
      x_en[n_rows] = ref_addr(en, 1, battle_pkg::ENEMY_X, battle_pkg::ENEMY_Y, x, y);
      x_enhit[n_rows] = in_window(battle_pkg::ENEMY_X, battle_pkg::ENEMY_Y, x, y);
      x_rgb[n_rows] = ref_rgb(x, y, mx, cur);
      x_bar[n_rows] = on_bar(x, y);
      n_rows++;
   endtask

   task automatic build_table();
      int rx;
      int ry;
      for (int id = 0; id < 8; id++) begin
         // window corners of my slot then the enemy slot
         for (int c = 0; c < 4; c++) begin
            add_row($sformatf("my corner id%0d c%0d", id, c), id, 7 - id, 100, 100,
                    battle_pkg::MY_X + 55 * (c % 2), battle_pkg::MY_Y + 55 * (c / 2));
            add_row($sformatf("enemy corner id%0d c%0d", id, c), 7 - id, id, 100, 100,
                    battle_pkg::ENEMY_X + 55 * (c % 2), battle_pkg::ENEMY_Y + 55 * (c / 2));
         end
         for (int r = 0; r < 2; r++) begin
            rx = int'((lcg_next() >> 8) % 56);
            ry = int'((lcg_next() >> 8) % 56);
            add_row($sformatf("my random id%0d", id), id, 0, 100, 100,
                    battle_pkg::MY_X + rx, battle_pkg::MY_Y + ry);
            add_row($sformatf("enemy random id%0d", id), 0, id, 100, 100,
                    battle_pkg::ENEMY_X + rx, battle_pkg::ENEMY_Y + ry);
         end
      end
      // just past each window edge
      add_row("my left", 3, 3, 100, 100, 249, 300);
      add_row("my right", 3, 3, 100, 100, 306, 300);
      add_row("my top", 3, 3, 100, 100, 260, 289);
      add_row("my bottom", 3, 3, 100, 100, 260, 346);
      add_row("enemy left", 3, 3, 100, 100, 409, 170);
      add_row("enemy right", 3, 3, 100, 100, 466, 170);
      add_row("enemy top", 3, 3, 100, 100, 420, 159);
      add_row("enemy bottom", 3, 3, 100, 100, 420, 216);
      // border ring
      add_row("ring top left", 0, 0, 100, 100, 279, 269);
      add_row("ring bottom right", 0, 0, 100, 100, 330, 275);
      add_row("ring top", 0, 0, 100, 100, 300, 269);
      add_row("ring bottom", 0, 0, 100, 100, 300, 275);
      add_row("ring left", 0, 0, 100, 100, 279, 272);
      add_row("ring right", 0, 0, 100, 100, 330, 272);
      // fill of 50 20 10 and 0 at max 100 on both sides of the boundary
      for (int k = 0; k < 4; k++) begin
         rx = (k == 0) ? 50 : (k == 1) ? 20 : (k == 2) ? 10 : 0;
         add_row($sformatf("fill %0d last", rx), 0, 0, 100, 2 * rx, 279 + rx, 272);
         add_row($sformatf("fill %0d next", rx), 0, 0, 100, 2 * rx, 280 + rx, 272);
      end
      add_row("max zero left", 0, 0, 0, 50, 280, 272);
      add_row("max zero right", 0, 0, 0, 50, 329, 272);
      add_row("bar outside left", 0, 0, 100, 100, 278, 272);
      add_row("bar outside top", 0, 0, 100, 100, 300, 268);
      add_row("bar outside right", 0, 0, 100, 100, 331, 272);
   endtask

   // one write with bready held off for hold cycles
   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
         input logic [3:0] strb, input int hold);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      do @(posedge clk); while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      repeat (hold) begin
         @(posedge clk);
         check_flag("bvalid held", 1'b1, bvalid);
      end
      bready <= 1'b1;
      do @(posedge clk); while (!bvalid);
      check_resp("write response", 2'b00, bresp);
      bready <= 1'b0;
   endtask

   // one read with rready held off for hold cycles
   task automatic read_expect(input string name, input logic [3:0] addr,
         input battle_pkg::hp_t exp, input int hold);
      logic [31:0] first;
      araddr  <= addr;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      first = rdata;
      check_resp({name, " rresp"}, 2'b00, rresp);
      repeat (hold) begin
         @(posedge clk);
         check_flag({name, " rvalid held"}, 1'b1, rvalid);
         check_flag({name, " rdata held"}, 1'b1, rdata == first);
      end
      check_hp(name, exp, battle_pkg::hp_t'(first));
      check_flag({name, " upper bits zero"}, 1'b1, first[31:7] == '0);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic set_regs(input int my, input int en, input int mx, input int cur);
      axi_write(battle_pkg::REG_MY_ID, my, 4'hf, 0);
      axi_write(battle_pkg::REG_ENEMY_ID, en, 4'hf, 0);
      axi_write(battle_pkg::REG_MAX_HP, mx, 4'hf, 0);
      axi_write(battle_pkg::REG_CUR_HP, cur, 4'hf, 0);
   endtask

   task automatic compare_pixel(input string name, input battle_pkg::sprite_addr_t e_my,
         input logic e_myhit, input battle_pkg::sprite_addr_t e_en, input logic e_enhit,
         input logic [23:0] e_rgb, input logic e_bar);
      check_addr({name, " my addr"}, e_my, my_sprite_addr);
      check_flag({name, " is_myteam"}, e_myhit, is_myteam);
      check_addr({name, " enemy addr"}, e_en, enemy_sprite_addr);
      check_flag({name, " is_enemyteam"}, e_enhit, is_enemyteam);
      check_color({name, " red"}, e_rgb[23:16], hp_r);
      check_color({name, " green"}, e_rgb[15:8], hp_g);
      check_color({name, " blue"}, e_rgb[7:0], hp_b);
      check_flag({name, " is_hpbar"}, e_bar, is_hpbar);
   endtask

   initial begin
      arst_n  = 1'b0;
      draw_x  = '0;
      draw_y  = '0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      build_table();
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      // register access with held responses
      axi_write(battle_pkg::REG_MY_ID, 5, 4'hf, 3);
      axi_write(battle_pkg::REG_ENEMY_ID, 6, 4'h1, 0);
      axi_write(battle_pkg::REG_MAX_HP, 90, 4'hf, 0);
      axi_write(battle_pkg::REG_CUR_HP, 33, 4'hf, 0);
      // lane 0 strobe off so the write is dropped
      axi_write(battle_pkg::REG_CUR_HP, 77, 4'he, 0);
      read_expect("readback my_id", battle_pkg::REG_MY_ID, 5, 3);
      read_expect("readback enemy_id", battle_pkg::REG_ENEMY_ID, 6, 0);
      read_expect("readback max_hp", battle_pkg::REG_MAX_HP, 90, 0);
      read_expect("readback cur_hp", battle_pkg::REG_CUR_HP, 33, 2);
      read_expect("unmapped read", 4'h2, 0, 0);

      // table rows one at a time
      for (int i = 0; i < n_rows; i++) begin
         set_regs(t_my[i], t_en[i], t_max[i], t_cur[i]);
         draw_x <= t_x[i];
         draw_y <= t_y[i];
         repeat (2) @(posedge clk);
         compare_pixel(t_name[i], x_my[i], x_myhit[i], x_en[i], x_enhit[i], x_rgb[i], x_bar[i]);
      end

      // back-to-back pixels with results trailing by one sampled pixel
      set_regs(3, 4, 100, 60);
      for (int k = 0; k < n_rows + 2; k++) begin
         if (k >= 2) begin
            compare_pixel($sformatf("pipe %0d", k - 2),
               ref_addr(3, 0, battle_pkg::MY_X, battle_pkg::MY_Y, t_x[k-2], t_y[k-2]),
               in_window(battle_pkg::MY_X, battle_pkg::MY_Y, t_x[k-2], t_y[k-2]),
               ref_addr(4, 1, battle_pkg::ENEMY_X, battle_pkg::ENEMY_Y, t_x[k-2], t_y[k-2]),
               in_window(battle_pkg::ENEMY_X, battle_pkg::ENEMY_Y, t_x[k-2], t_y[k-2]),
               ref_rgb(t_x[k-2], t_y[k-2], 100, 60), on_bar(t_x[k-2], t_y[k-2]));
         end
         if (k < n_rows) begin
            draw_x <= t_x[k];
            draw_y <= t_y[k];
         end
         @(posedge clk);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/battle_pkg.sv
hdl/battle_regs.sv
hdl/sprite_window.sv
hdl/hp_bar.sv
hdl/battle_scene.sv
test/tb_battle_scene.sv

// ==== Bender.yml ====
package:
  name: battle_scene

sources:
  - hdl/battle_pkg.sv
  - hdl/battle_regs.sv
  - hdl/sprite_window.sv
  - hdl/hp_bar.sv
  - hdl/battle_scene.sv
  - target: test
    files:
      - test/tb_battle_scene.sv
